// ==== build.f ====
verilog/cluster_periph_pkg.sv
verilog/periph_slot_demux.sv
verilog/cluster_ctrl_regs.sv
verilog/cluster_timer.sv
verilog/cluster_event_unit.sv
verilog/cluster_peripherals.sv
verif/cluster_peripherals_props.sv
verif/cluster_peripherals_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it; exits 0 only on a passing run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module cluster_peripherals_tb \
  -f build.f -o cluster_peripherals_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/cluster_peripherals_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1

// ==== verif/cluster_peripherals_props.sv ====
// sampled at rising clk_i outside reset; pending comes from the event unit's internal vector
`timescale 1ns/1ps
`default_nettype none

module cluster_peripherals_props #(
  parameter int unsigned NB_CORES = 4
) (
  input logic                             clk_i,
  input logic                             rst_ni,
  input logic                             req_ready_i,
  input logic                             resp_valid_i,
  input logic                             resp_ready_i,
  input cluster_periph_pkg::periph_resp_t resp_i,
  input logic [NB_CORES-1:0]              irq_req_i,
  input cluster_periph_pkg::evt_vec_t     pending_i
);

  // only one transaction in flight
  a_single_txn : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_ready_i && resp_valid_i))
    else $error("req_ready_o high while a response is still waiting");

  a_resp_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (resp_valid_i && !resp_ready_i) |=> (resp_valid_i && $stable(resp_i)))
    else $error("response dropped or changed under back-pressure");

  a_irq_pending : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|irq_req_i) |-> (|pending_i))
    else $error("interrupt request with nothing pending");

endmodule

bind cluster_peripherals cluster_peripherals_props #(.NB_CORES(NB_CORES)) i_props (
  .clk_i        ( clk_i                  ),
  .rst_ni       ( rst_ni                 ),
  .req_ready_i  ( req_ready_o            ),
  .resp_valid_i ( resp_valid_o           ),
  .resp_ready_i ( resp_ready_i           ),
  .resp_i       ( resp_o                 ),
  .irq_req_i    ( irq_req_o              ),
  .pending_i    ( i_event_unit.pending_q )
);

`default_nettype wire

// ==== verif/cluster_peripherals_tb.sv ====
// NB_CORES fixed at 4; slots sit at 1 KiB steps from address 0 and inputs change 1 ns after a rising edge
`timescale 1ns/1ps
`default_nettype none

module cluster_peripherals_tb;

  import cluster_periph_pkg::*;

  localparam int unsigned NB_CORES  = 4;
  localparam addr_t       BOOT_ADDR = 32'h1C00_0000;
  localparam int          TIMEOUT   = 40;
  localparam int          N_ACC     = 10;
  localparam logic [31:0] SEED      = 32'h59a0_e707;

  // one row of the stimulus table
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
    data_t exp_rdata;
    logic  exp_err;
  } access_t;

  logic                      clk_i, rst_ni;
  logic                      req_valid_i, req_ready_o, resp_valid_o, resp_ready_i;
  periph_req_t               req_i;
  periph_resp_t              resp_o;
  logic                      eoc_o, busy_o, soc_evt_valid_i, soc_evt_ready_o;
  logic [NB_CORES-1:0]       fetch_enable_o, irq_req_o, irq_ack_i;
  addr_t                     boot_addr_o;
  logic [NB_EXT_EVT-1:0]     ext_evt_i;
  soc_evt_t                  soc_evt_data_i;
  irq_id_t [NB_CORES-1:0]    irq_id_o;
  access_t                   access_tbl [N_ACC];
  int                        errors = 0;
  int                        tests = 0;

  cluster_peripherals #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) DUT (.*);

  always #50 clk_i = ~clk_i;

  // *********************************************************************
  // helpers
  // *********************************************************************

  function automatic addr_t reg_addr(input periph_slot_e slot, input reg_ofs_t ofs);
    return {20'h0, slot, 4'h0, ofs, 2'b00};
  endfunction

  function automatic access_t make_access(input addr_t a, input logic we, input data_t wd,
                                          input data_t exp, input logic err);
    return '{addr: a, we: we, wdata: wd, exp_rdata: exp, exp_err: err};
  endfunction

  task automatic check_value(input string name, input data_t got, input data_t exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic finish_test(input string name, input int err0);
    tests++;
    if (errors == err0) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - err0);
  endtask

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  // one bus transaction; stall holds resp_ready_i low for that many cycles
  task automatic do_access(input addr_t addr, input logic we, input data_t wdata,
                           input int stall, output periph_resp_t resp);
    int cycles;
    resp = '0;
    cycles = 0;
    req_i = '{addr: addr, we: we, wdata: wdata};
    req_valid_i = 1'b1;
    resp_ready_i = (stall == 0);
    while (!req_ready_o && cycles < TIMEOUT) begin
      step();
      cycles++;
    end
    if (!req_ready_o) begin
      report_failure("request was never accepted");
      req_valid_i = 1'b0;
      return;
    end
    step();
    req_valid_i = 1'b0;
    cycles = 1;
    while (!resp_valid_o && cycles < TIMEOUT) begin
      step();
      cycles++;
    end
    if (!resp_valid_o) begin
      report_failure("no response arrived");
      resp_ready_i = 1'b1;
      return;
    end
    check_value("response latency", data_t'(cycles), 32'd2);
    resp = resp_o;
    for (int i = 0; i < stall; i++) begin
      step();
      check_value("resp_valid_o", data_t'(resp_valid_o), 32'd1);
      check_value("resp_o.rdata", resp_o.rdata, resp.rdata);
      check_value("resp_o.err", data_t'(resp_o.err), data_t'(resp.err));
      check_value("req_ready_o", data_t'(req_ready_o), 32'd0);
    end
    resp_ready_i = 1'b1;
    step();
  endtask

  // *********************************************************************
  // directed sequences
  // *********************************************************************

  task automatic run_timer_irq();
    periph_resp_t r;
    int           cycles;
    int           err0;
    err0 = errors;
    do_access(reg_addr(SLOT_TIMER, TIMER_CMP), 1'b1, 32'd20, 0, r);
    do_access(reg_addr(SLOT_EVENT, EU_MASK_BASE), 1'b1, data_t'(1) << EVT_TIMER_BIT, 0, r);
    do_access(reg_addr(SLOT_TIMER, TIMER_CFG), 1'b1, 32'd1, 0, r);
    check_value("busy_o", data_t'(busy_o), 32'd1);
    cycles = 0;
    while (!irq_req_o[0] && cycles < 4 * TIMEOUT) begin
      check_value("irq_req_o[1]", data_t'(irq_req_o[1]), 32'd0);
      step();
      cycles++;
    end
    if (!irq_req_o[0]) report_failure("core 0 got no timer interrupt");
    check_value("irq_id_o[0]", data_t'(irq_id_o[0]), data_t'(EVT_TIMER_BIT));
    irq_ack_i[0] = 1'b1;
    step();
    irq_ack_i[0] = 1'b0;
    check_value("irq_req_o[0]", data_t'(irq_req_o[0]), 32'd0);
    check_value("irq_req_o[1]", data_t'(irq_req_o[1]), 32'd0);
    // stop the timer and drop whatever it left pending
    do_access(reg_addr(SLOT_TIMER, TIMER_CFG), 1'b1, 32'd0, 0, r);
    check_value("busy_o", data_t'(busy_o), 32'd0);
    do_access(reg_addr(SLOT_EVENT, EU_MASK_BASE), 1'b1, 32'd0, 0, r);
    do_access(reg_addr(SLOT_EVENT, EU_CLEAR), 1'b1, '1, 0, r);
    finish_test("timer interrupt", err0);
  endtask

  task automatic run_events();
    periph_resp_t r;
    soc_evt_t     data;
    data_t        ext_bit, soc_bit;
    int           cycles;
    int           err0;
    err0 = errors;
    data = soc_evt_t'($urandom);
    ext_bit = data_t'(1) << (EVT_EXT_LSB + 1);
    soc_bit = data_t'(1) << EVT_SOC_BIT;
    ext_evt_i[1] = 1'b1;
    step();
    ext_evt_i[1] = 1'b0;
    do_access(reg_addr(SLOT_EVENT, EU_PENDING), 1'b0, '0, 0, r);
    check_value("EU_PENDING", r.rdata, ext_bit);
    soc_evt_valid_i = 1'b1;
    soc_evt_data_i = data;
    cycles = 0;
    while (!soc_evt_ready_o && cycles < TIMEOUT) begin
      step();
      cycles++;
    end
    if (!soc_evt_ready_o) report_failure("SoC event was never accepted");
    step();
    soc_evt_valid_i = 1'b0;
    check_value("soc_evt_ready_o", data_t'(soc_evt_ready_o), 32'd0);
    do_access(reg_addr(SLOT_EVENT, EU_SOC_DATA), 1'b0, '0, 0, r);
    check_value("EU_SOC_DATA", r.rdata, data_t'(data));
    do_access(reg_addr(SLOT_EVENT, EU_PENDING), 1'b0, '0, 0, r);
    check_value("EU_PENDING", r.rdata, ext_bit | soc_bit);
    check_value("soc_evt_ready_o", data_t'(soc_evt_ready_o), 32'd0);
    do_access(reg_addr(SLOT_EVENT, EU_CLEAR), 1'b1, soc_bit, 0, r);
    check_value("soc_evt_ready_o", data_t'(soc_evt_ready_o), 32'd1);
    do_access(reg_addr(SLOT_EVENT, EU_PENDING), 1'b0, '0, 0, r);
    check_value("EU_PENDING", r.rdata, ext_bit);
    do_access(reg_addr(SLOT_EVENT, EU_CLEAR), 1'b1, '1, 0, r);
    finish_test("events", err0);
  endtask

  // *********************************************************************
  // main sequence
  // *********************************************************************

  initial begin
    periph_resp_t r;
    data_t        r_eoc, r_fe, r_boot, r_err;
    int           err0;
    void'($urandom(SEED));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    req_valid_i = 1'b0;
    req_i = '0;
    resp_ready_i = 1'b1;
    ext_evt_i = '0;
    soc_evt_valid_i = 1'b0;
    soc_evt_data_i = '0;
    irq_ack_i = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    err0 = errors;
    check_value("req_ready_o", data_t'(req_ready_o), 32'd1);
    check_value("resp_valid_o", data_t'(resp_valid_o), 32'd0);
    check_value("eoc_o", data_t'(eoc_o), 32'd0);
    check_value("fetch_enable_o", data_t'(fetch_enable_o), 32'd0);
    check_value("irq_req_o", data_t'(irq_req_o), 32'd0);
    check_value("busy_o", data_t'(busy_o), 32'd0);
    check_value("soc_evt_ready_o", data_t'(soc_evt_ready_o), 32'd1);
    check_value("boot_addr_o", boot_addr_o, BOOT_ADDR);
    finish_test("reset state", err0);

    r_eoc = $urandom;
    r_fe = $urandom;
    r_boot = $urandom;
    r_err = $urandom;
    access_tbl[0] = make_access(reg_addr(SLOT_CTRL, CTRL_BOOT_ADDR), 1'b0, '0, BOOT_ADDR, 1'b0);
    access_tbl[1] = make_access(reg_addr(SLOT_CTRL, CTRL_EOC), 1'b1, r_eoc, '0, 1'b0);
    access_tbl[2] = make_access(reg_addr(SLOT_CTRL, CTRL_EOC), 1'b0, '0, r_eoc & 32'd1, 1'b0);
    access_tbl[3] = make_access(reg_addr(SLOT_CTRL, CTRL_FETCH_EN), 1'b1, r_fe, '0, 1'b0);
    access_tbl[4] = make_access(reg_addr(SLOT_CTRL, CTRL_FETCH_EN), 1'b0, '0,
                                r_fe & data_t'((1 << NB_CORES) - 1), 1'b0);
    access_tbl[5] = make_access(reg_addr(SLOT_CTRL, CTRL_BOOT_ADDR), 1'b1, r_boot, '0, 1'b0);
    access_tbl[6] = make_access(reg_addr(SLOT_CTRL, CTRL_BOOT_ADDR), 1'b0, '0, r_boot, 1'b0);
    access_tbl[7] = make_access(reg_addr(SLOT_ERROR, 4'd0), 1'b1, r_err, ERR_RDATA, 1'b1);
    access_tbl[8] = make_access(reg_addr(SLOT_ERROR, 4'd5), 1'b0, '0, ERR_RDATA, 1'b1);
    access_tbl[9] = make_access(reg_addr(SLOT_CTRL, 4'd7), 1'b0, '0, '0, 1'b0);

    for (int i = 0; i < N_ACC; i++) begin
      err0 = errors;
      do_access(access_tbl[i].addr, access_tbl[i].we, access_tbl[i].wdata, 0, r);
      check_value("resp_o.rdata", r.rdata, access_tbl[i].exp_rdata);
      check_value("resp_o.err", data_t'(r.err), data_t'(access_tbl[i].exp_err));
      finish_test($sformatf("access %0d", i), err0);
    end

    err0 = errors;
    check_value("eoc_o", data_t'(eoc_o), r_eoc & 32'd1);
    check_value("fetch_enable_o", data_t'(fetch_enable_o), r_fe & data_t'((1 << NB_CORES) - 1));
    check_value("boot_addr_o", boot_addr_o, r_boot);
    finish_test("control outputs", err0);

    run_timer_irq();
    run_events();

    err0 = errors;
    do_access(reg_addr(SLOT_CTRL, CTRL_BOOT_ADDR), 1'b0, '0, 5, r);
    check_value("resp_o.rdata", r.rdata, r_boot);
    check_value("resp_valid_o", data_t'(resp_valid_o), 32'd0);
    finish_test("back-pressure", err0);

    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cluster_ctrl_regs.sv ====
// writes return 0 as read data; fetch enable is NB_CORES bits wide, upper write data is dropped
`timescale 1ns/1ps
`default_nettype none

module cluster_ctrl_regs #(
  parameter int unsigned               NB_CORES  = 4,
  parameter cluster_periph_pkg::addr_t BOOT_ADDR = 32'h1C00_0000
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            sel_i,
  input  cluster_periph_pkg::periph_req_t req_i,
  output cluster_periph_pkg::data_t       rdata_o,
  output logic                            eoc_o,
  output logic [NB_CORES-1:0]             fetch_enable_o,
  output cluster_periph_pkg::addr_t       boot_addr_o
);

  import cluster_periph_pkg::*;

  logic                eoc_q;
  logic [NB_CORES-1:0] fetch_en_q;
  addr_t               boot_addr_q;
  reg_ofs_t            ofs;
  logic                wr;
  data_t               rdata_d, rdata_q;

  assign ofs = addr_ofs(req_i.addr);
  assign wr  = sel_i && req_i.we;

  // *******************************************************************
  // registers
  // *******************************************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      eoc_q       <= 1'b0;
      fetch_en_q  <= '0;
      boot_addr_q <= BOOT_ADDR;
    end else if (wr) begin
      case (ofs)
        CTRL_EOC:       eoc_q       <= req_i.wdata[0];
        CTRL_FETCH_EN:  fetch_en_q  <= req_i.wdata[NB_CORES-1:0];
        CTRL_BOOT_ADDR: boot_addr_q <= req_i.wdata;
        default:        ;
      endcase
    end
  end

  // *******************************************************************
  // read path
  // *******************************************************************

  always_comb begin
    rdata_d = '0;
    if (!req_i.we) begin
      case (ofs)
        CTRL_EOC:       rdata_d = data_t'(eoc_q);
        CTRL_FETCH_EN:  rdata_d = data_t'(fetch_en_q);
        CTRL_BOOT_ADDR: rdata_d = boot_addr_q;
        default:        rdata_d = '0;
      endcase
    end
  end

  // held until the demux picks it up in the next cycle
  always_ff @(posedge clk_i) begin
    if (sel_i) rdata_q <= rdata_d;
  end

  assign rdata_o        = rdata_q;
  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

`default_nettype wire

// ==== verilog/cluster_event_unit.sv ====
// one pending vector shared by all cores; set beats clear on the same bit, acks count only while requesting
`timescale 1ns/1ps
`default_nettype none

module cluster_event_unit #(
  parameter int unsigned NB_CORES = 4
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           sel_i,
  input  cluster_periph_pkg::periph_req_t                req_i,
  output cluster_periph_pkg::data_t                      rdata_o,
  input  logic                                           timer_evt_i,
  input  logic [cluster_periph_pkg::NB_EXT_EVT-1:0]      ext_evt_i,
  input  logic                                           soc_evt_valid_i,
  input  cluster_periph_pkg::soc_evt_t                   soc_evt_data_i,
  output logic                                           soc_evt_ready_o,
  output logic [NB_CORES-1:0]                            irq_req_o,
  output cluster_periph_pkg::irq_id_t [NB_CORES-1:0]     irq_id_o,
  input  logic [NB_CORES-1:0]                            irq_ack_i
);

  import cluster_periph_pkg::*;

  evt_vec_t                pending_q, pending_d;
  evt_vec_t                evt_set, evt_clr;
  evt_vec_t [NB_CORES-1:0] mask_q;
  evt_vec_t [NB_CORES-1:0] masked;
  soc_evt_t                soc_data_q;
  logic                    soc_hs;
  reg_ofs_t                ofs;
  logic                    wr;
  data_t                   rdata_d, rdata_q;

  // lowest set bit wins the arbitration
  function automatic irq_id_t lowest_bit(evt_vec_t vec);
    irq_id_t id;
    id = '0;
    for (int i = EVT_WIDTH - 1; i >= 0; i--) begin
      if (vec[i]) id = irq_id_t'(i);
    end
    return id;
  endfunction

  assign ofs             = addr_ofs(req_i.addr);
  assign wr              = sel_i && req_i.we;
  assign soc_evt_ready_o = !pending_q[EVT_SOC_BIT];
  assign soc_hs          = soc_evt_valid_i && soc_evt_ready_o;

  // *******************************************************************
  // pending vector
  // *******************************************************************

  always_comb begin
    evt_set                                = '0;
    evt_set[EVT_TIMER_BIT]                 = timer_evt_i;
    evt_set[EVT_EXT_LSB +: NB_EXT_EVT]     = ext_evt_i;
    evt_set[EVT_SOC_BIT]                   = soc_hs;
    evt_clr = '0;
    if (wr && ofs == EU_CLEAR) evt_clr = req_i.wdata[EVT_WIDTH-1:0];
    for (int c = 0; c < NB_CORES; c++) begin
      if (irq_ack_i[c] && irq_req_o[c]) evt_clr[irq_id_o[c]] = 1'b1;
    end
    pending_d = (pending_q & ~evt_clr) | evt_set;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
      mask_q    <= '0;
    end else begin
      pending_q <= pending_d;
      for (int c = 0; c < NB_CORES; c++) begin
        if (wr && ofs == EU_MASK_BASE + reg_ofs_t'(c)) mask_q[c] <= req_i.wdata[EVT_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (soc_hs) soc_data_q <= soc_evt_data_i;
  end

  // *******************************************************************
  // per core interrupt request
  // *******************************************************************

  for (genvar c = 0; c < NB_CORES; c++) begin : gen_core_irq
    assign masked[c]    = pending_q & mask_q[c];
    assign irq_req_o[c] = |masked[c];
    assign irq_id_o[c]  = lowest_bit(masked[c]);
  end

  // read path, masks first then the fixed registers
  always_comb begin
    rdata_d = '0;
    if (!req_i.we) begin
      for (int c = 0; c < NB_CORES; c++) begin
        if (ofs == EU_MASK_BASE + reg_ofs_t'(c)) rdata_d = data_t'(mask_q[c]);
      end
      if (ofs == EU_PENDING)  rdata_d = data_t'(pending_q);
      if (ofs == EU_SOC_DATA) rdata_d = data_t'(soc_data_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) rdata_q <= rdata_d;
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/cluster_periph_pkg.sv ====
// shared types and address map; word accesses only, slot taken from addr[11:10], offset from addr[5:2]
`default_nettype none

package cluster_periph_pkg;

  // *******************************************************************
  // bus types
  // *******************************************************************

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
  } periph_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } periph_resp_t;

  // one 1 KiB slot per peripheral
  typedef enum logic [1:0] {
    SLOT_CTRL  = 2'd0,
    SLOT_TIMER = 2'd1,
    SLOT_EVENT = 2'd2,
    SLOT_ERROR = 2'd3
  } periph_slot_e;

  typedef logic [3:0] reg_ofs_t;

  // *******************************************************************
  // events
  // *******************************************************************

  localparam int unsigned EVT_WIDTH     = 8;
  localparam int unsigned NB_EXT_EVT    = 3;
  localparam int unsigned EVT_TIMER_BIT = 0;
  localparam int unsigned EVT_EXT_LSB   = 1;
  localparam int unsigned EVT_SOC_BIT   = 4;

  typedef logic [EVT_WIDTH-1:0] evt_vec_t;
  typedef logic [2:0]           irq_id_t;
  typedef logic [7:0]           soc_evt_t;

  localparam data_t ERR_RDATA = 32'hBADC_AB7E;

  // *******************************************************************
  // register offsets, in words
  // *******************************************************************

  localparam reg_ofs_t CTRL_EOC       = 4'd0;
  localparam reg_ofs_t CTRL_FETCH_EN  = 4'd1;
  localparam reg_ofs_t CTRL_BOOT_ADDR = 4'd2;

  localparam reg_ofs_t TIMER_CFG   = 4'd0;
  localparam reg_ofs_t TIMER_COUNT = 4'd1;
  localparam reg_ofs_t TIMER_CMP   = 4'd2;

  // mask of core c sits at EU_MASK_BASE + c
  localparam reg_ofs_t EU_MASK_BASE = 4'd0;
  localparam reg_ofs_t EU_PENDING   = 4'd8;
  localparam reg_ofs_t EU_CLEAR     = 4'd9;
  localparam reg_ofs_t EU_SOC_DATA  = 4'd10;

  function automatic periph_slot_e addr_slot(addr_t addr);
    return periph_slot_e'(addr[11:10]);
  endfunction

  function automatic reg_ofs_t addr_ofs(addr_t addr);
    return addr[5:2];
  endfunction

endpackage

`default_nettype wire

// ==== verilog/cluster_peripherals.sv ====
// NB_CORES from 1 to 8; word-only config bus with a single outstanding transaction
`timescale 1ns/1ps
`default_nettype none

module cluster_peripherals #(
  parameter int unsigned               NB_CORES  = 4,
  parameter cluster_periph_pkg::addr_t BOOT_ADDR = 32'h1C00_0000
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // configuration master
  input  logic                                       req_valid_i,
  input  cluster_periph_pkg::periph_req_t            req_i,
  output logic                                       req_ready_o,
  output logic                                       resp_valid_o,
  output cluster_periph_pkg::periph_resp_t           resp_o,
  input  logic                                       resp_ready_i,
  // cluster control
  output logic                                       eoc_o,
  output logic [NB_CORES-1:0]                        fetch_enable_o,
  output cluster_periph_pkg::addr_t                  boot_addr_o,
  output logic                                       busy_o,
  // events and interrupts
  input  logic [cluster_periph_pkg::NB_EXT_EVT-1:0]  ext_evt_i,
  input  logic                                       soc_evt_valid_i,
  input  cluster_periph_pkg::soc_evt_t               soc_evt_data_i,
  output logic                                       soc_evt_ready_o,
  output logic [NB_CORES-1:0]                        irq_req_o,
  output cluster_periph_pkg::irq_id_t [NB_CORES-1:0] irq_id_o,
  input  logic [NB_CORES-1:0]                        irq_ack_i
);

  import cluster_periph_pkg::*;

  periph_req_t periph_req;
  logic        ctrl_sel, timer_sel, eu_sel;
  data_t       ctrl_rdata, timer_rdata, eu_rdata;
  logic        timer_evt;

  // *******************************************************************
  // slot decode
  // *******************************************************************

  periph_slot_demux i_demux (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .req_valid_i   ( req_valid_i  ),
    .req_i         ( req_i        ),
    .req_ready_o   ( req_ready_o  ),
    .resp_valid_o  ( resp_valid_o ),
    .resp_o        ( resp_o       ),
    .resp_ready_i  ( resp_ready_i ),
    .req_o         ( periph_req   ),
    .ctrl_sel_o    ( ctrl_sel     ),
    .timer_sel_o   ( timer_sel    ),
    .eu_sel_o      ( eu_sel       ),
    .ctrl_rdata_i  ( ctrl_rdata   ),
    .timer_rdata_i ( timer_rdata  ),
    .eu_rdata_i    ( eu_rdata     )
  );

  // *******************************************************************
  // peripherals
  // *******************************************************************

  cluster_ctrl_regs #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) i_ctrl_regs (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .sel_i          ( ctrl_sel       ),
    .req_i          ( periph_req     ),
    .rdata_o        ( ctrl_rdata     ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer i_timer (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .sel_i       ( timer_sel   ),
    .req_i       ( periph_req  ),
    .rdata_o     ( timer_rdata ),
    .timer_evt_o ( timer_evt   ),
    .busy_o      ( busy_o      )
  );

  cluster_event_unit #(
    .NB_CORES ( NB_CORES )
  ) i_event_unit (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .sel_i           ( eu_sel          ),
    .req_i           ( periph_req      ),
    .rdata_o         ( eu_rdata        ),
    .timer_evt_i     ( timer_evt       ),
    .ext_evt_i       ( ext_evt_i       ),
    .soc_evt_valid_i ( soc_evt_valid_i ),
    .soc_evt_data_i  ( soc_evt_data_i  ),
    .soc_evt_ready_o ( soc_evt_ready_o ),
    .irq_req_o       ( irq_req_o       ),
    .irq_id_o        ( irq_id_o        ),
    .irq_ack_i       ( irq_ack_i       )
  );

endmodule

`default_nettype wire

// ==== verilog/cluster_timer.sv ====
// compare resets to all ones; a count write in the match cycle wins and the event is skipped
`timescale 1ns/1ps
`default_nettype none

module cluster_timer (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            sel_i,
  input  cluster_periph_pkg::periph_req_t req_i,
  output cluster_periph_pkg::data_t       rdata_o,
  output logic                            timer_evt_o,
  output logic                            busy_o
);

  import cluster_periph_pkg::*;

  logic     en_q;
  data_t    count_q;
  data_t    cmp_q;
  logic     evt_q;
  logic     match;
  reg_ofs_t ofs;
  logic     wr;
  data_t    rdata_d, rdata_q;

  assign ofs   = addr_ofs(req_i.addr);
  assign wr    = sel_i && req_i.we;
  assign match = en_q && (count_q == cmp_q);

  // *******************************************************************
  // counter and configuration
  // *******************************************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_q    <= 1'b0;
      count_q <= '0;
      cmp_q   <= '1;
      evt_q   <= 1'b0;
    end else begin
      // pulse lines up with the cycle where the counter shows 0
      evt_q <= match && !(wr && ofs == TIMER_COUNT);
      if (wr && ofs == TIMER_CFG) en_q <= req_i.wdata[0];
      if (wr && ofs == TIMER_CMP) cmp_q <= req_i.wdata;
      if (wr && ofs == TIMER_COUNT) begin
        count_q <= req_i.wdata;
      end else if (match) begin
        count_q <= '0;
      end else if (en_q) begin
        count_q <= count_q + 32'd1;
      end
    end
  end

  // *******************************************************************
  // read path
  // *******************************************************************

  always_comb begin
    rdata_d = '0;
    if (!req_i.we) begin
      case (ofs)
        TIMER_CFG:   rdata_d = data_t'(en_q);
        TIMER_COUNT: rdata_d = count_q;
        TIMER_CMP:   rdata_d = cmp_q;
        default:     rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) rdata_q <= rdata_d;
  end

  assign rdata_o     = rdata_q;
  assign timer_evt_o = evt_q;
  assign busy_o      = en_q;

endmodule

`default_nettype wire

// ==== verilog/periph_slot_demux.sv ====
// one transaction in flight; response valid two cycles after accept, slot 3 answered here with err
`timescale 1ns/1ps
`default_nettype none

module periph_slot_demux (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_valid_i,
  input  cluster_periph_pkg::periph_req_t  req_i,
  output logic                             req_ready_o,
  output logic                             resp_valid_o,
  output cluster_periph_pkg::periph_resp_t resp_o,
  input  logic                             resp_ready_i,
  output cluster_periph_pkg::periph_req_t  req_o,
  output logic                             ctrl_sel_o,
  output logic                             timer_sel_o,
  output logic                             eu_sel_o,
  input  cluster_periph_pkg::data_t        ctrl_rdata_i,
  input  cluster_periph_pkg::data_t        timer_rdata_i,
  input  cluster_periph_pkg::data_t        eu_rdata_i
);

  import cluster_periph_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    RESP
  } state_e;

  state_e       state_q, state_d;
  periph_slot_e slot, slot_q;
  periph_resp_t resp_d, resp_q;
  logic         accept;

  assign slot   = addr_slot(req_i.addr);
  assign accept = req_valid_i && (state_q == IDLE);

  // request goes to every slave, only the selected one acts on it
  assign req_o       = req_i;
  assign ctrl_sel_o  = accept && (slot == SLOT_CTRL);
  assign timer_sel_o = accept && (slot == SLOT_TIMER);
  assign eu_sel_o    = accept && (slot == SLOT_EVENT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept) state_d = WAIT;
      WAIT:    state_d = RESP;
      RESP:    if (resp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // slaves registered their read data on the select cycle
  always_comb begin
    resp_d.err = 1'b0;
    case (slot_q)
      SLOT_CTRL:  resp_d.rdata = ctrl_rdata_i;
      SLOT_TIMER: resp_d.rdata = timer_rdata_i;
      SLOT_EVENT: resp_d.rdata = eu_rdata_i;
      default: begin
        resp_d.rdata = ERR_RDATA;
        resp_d.err   = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) slot_q <= slot;
    if (state_q == WAIT) resp_q <= resp_d;
  end

  assign req_ready_o  = (state_q == IDLE);
  assign resp_valid_o = (state_q == RESP);
  assign resp_o       = resp_q;

endmodule

`default_nettype wire
